//--- verilog/dhcp_params.svh
`ifndef DHCP_PARAMS_SVH
`define DHCP_PARAMS_SVH

// Transaction id of the first attempt, later attempts add their count
`define DHCP_XID_BASE 32'h3c5a_0000

// Magic cookie that follows chaddr in every frame
`define DHCP_COOKIE 32'h6382_5363

// Clock cycles the client waits for a reply once its frame has left
`define DHCP_TIMEOUT_CYCLES 2000

// Attempts per phase before the client gives up
`define DHCP_MAX_RETRIES 3

`endif

//--- verilog/dhcp_pkg.sv
package dhcp_pkg;

  // Client sequencer states, also reported through the status register
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_discover   = 3'd1,
    st_offer_wait = 3'd2,
    st_request    = 3'd3,
    st_ack_wait   = 3'd4,
    st_bound      = 3'd5,
    st_failed     = 3'd6
  } dhcp_state_t;

  // Value carried in option 53
  typedef enum logic [7:0] {
    msg_discover = 8'd1,
    msg_offer    = 8'd2,
    msg_request  = 8'd3,
    msg_ack      = 8'd5,
    msg_nak      = 8'd6
  } dhcp_msg_t;

  typedef enum logic [7:0] {
    reg_ctrl      = 8'h00,
    reg_mac_lo    = 8'h04,
    reg_mac_hi    = 8'h08,
    reg_status    = 8'h0C,
    reg_lease_ip  = 8'h10,
    reg_server_ip = 8'h14
  } dhcp_reg_t;

  // BOOTP op field
  typedef enum logic [7:0] {
    op_request = 8'd1,
    op_reply   = 8'd2
  } bootp_op_t;

  // Option codes that the framer emits or the parser keeps
  typedef enum logic [7:0] {
    opt_pad       = 8'd0,
    opt_req_ip    = 8'd50,
    opt_msg_type  = 8'd53,
    opt_server_id = 8'd54,
    opt_end       = 8'd255
  } dhcp_opt_t;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;

endpackage

//--- verilog/dhcp_apb_regs.sv
`timescale 1ns/1ps

module dhcp_apb_regs (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  start,
  output dhcp_pkg::mac_t        mac,
  input  dhcp_pkg::dhcp_state_t state,
  input  dhcp_pkg::ipv4_t       lease_ip,
  input  dhcp_pkg::ipv4_t       server_ip
);
  import dhcp_pkg::*;

  logic        hit;
  logic        setup;
  logic        wr_acc;
  logic [31:0] rdata;

  assign pready = 1'b1;
  assign setup  = psel && !penable;
  assign wr_acc = psel && penable && pwrite && hit;
  assign start  = wr_acc && (paddr == reg_ctrl) && pwdata[0];

  always_comb begin
    hit   = 1'b1;
    rdata = 32'd0;
    case (paddr)
      reg_ctrl:      rdata = 32'd0;
      reg_mac_lo:    rdata = mac[31:0];
      reg_mac_hi:    rdata = {16'd0, mac[47:32]};
      reg_status:    rdata = {26'd0, state == st_failed, state == st_bound, 1'b0, state};
      reg_lease_ip:  rdata = lease_ip;
      reg_server_ip: rdata = server_ip;
      default:       hit = 1'b0;
    endcase
  end

  // Read data and the error flag are set up so they are valid in the access phase
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      prdata  <= 32'd0;
      pslverr <= 1'b0;
    end else if (setup) begin
      prdata  <= (pwrite || !hit) ? 32'd0 : rdata;
      pslverr <= !hit;
    end else begin
      prdata  <= 32'd0;
      pslverr <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      mac <= '0;
    end else if (wr_acc) begin
      case (paddr)
        reg_mac_lo: mac[31:0]  <= pwdata;
        reg_mac_hi: mac[47:32] <= pwdata[15:0];
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/dhcp_core.sv
`timescale 1ns/1ps
`include "dhcp_params.svh"

module dhcp_core (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  start,
  input  logic                  busy,
  input  logic                  msg_val,
  input  dhcp_pkg::dhcp_msg_t   msg_type,
  input  logic [31:0]           msg_xid,
  input  dhcp_pkg::ipv4_t       msg_yiaddr,
  input  dhcp_pkg::ipv4_t       msg_server_id,
  output logic                  send,
  output dhcp_pkg::dhcp_msg_t   send_type,
  output logic [31:0]           xid,
  output dhcp_pkg::ipv4_t       req_ip,
  output dhcp_pkg::ipv4_t       srv_ip,
  output dhcp_pkg::dhcp_state_t state,
  output dhcp_pkg::ipv4_t       lease_ip,
  output dhcp_pkg::ipv4_t       server_ip
);
  import dhcp_pkg::*;

  logic [7:0]  xid_cnt;
  logic [15:0] tmo_cnt;
  logic [3:0]  retry_cnt;
  logic        waiting;
  logic        tmo_hit;
  logic        last_try;
  logic        msg_match;

  assign xid       = `DHCP_XID_BASE + {24'd0, xid_cnt};
  assign send      = ((state == st_discover) || (state == st_request)) && !busy;
  assign send_type = (state == st_request) ? msg_request : msg_discover;
  assign waiting   = (state == st_offer_wait) || (state == st_ack_wait);
  assign tmo_hit   = !busy && (tmo_cnt == 16'(`DHCP_TIMEOUT_CYCLES - 1));
  assign last_try  = (retry_cnt == 4'(`DHCP_MAX_RETRIES - 1));
  assign msg_match = msg_val && (msg_xid == xid);

  // The wait only counts once the framer has put the last byte out
  always_ff @(posedge clk) begin
    if (fsm_rst || !waiting || busy) begin
      tmo_cnt <= '0;
    end else begin
      tmo_cnt <= tmo_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= st_idle;
      xid_cnt   <= '0;
      retry_cnt <= '0;
      lease_ip  <= '0;
      server_ip <= '0;
    end else begin
      case (state)
        st_idle, st_bound, st_failed: begin
          if (start) begin
            state     <= st_discover;
            retry_cnt <= '0;
            if (state != st_idle) begin
              xid_cnt <= xid_cnt + 8'd1;
            end
          end
        end
        st_discover: begin
          if (send) begin
            state <= st_offer_wait;
          end
        end
        st_request: begin
          if (send) begin
            state <= st_ack_wait;
          end
        end
        st_offer_wait: begin
          if (msg_match && (msg_type == msg_offer)) begin
            state     <= st_request;
            retry_cnt <= '0;
          end else if (tmo_hit) begin
            if (last_try) begin
              state <= st_failed;
            end else begin
              // A fresh DISCOVER gets a fresh transaction id
              state     <= st_discover;
              retry_cnt <= retry_cnt + 4'd1;
              xid_cnt   <= xid_cnt + 8'd1;
            end
          end
        end
        st_ack_wait: begin
          if (msg_match && (msg_type == msg_ack)) begin
            state     <= st_bound;
            lease_ip  <= msg_yiaddr;
            server_ip <= srv_ip;
          end else if (msg_match && (msg_type == msg_nak)) begin
            state     <= st_discover;
            retry_cnt <= '0;
            xid_cnt   <= xid_cnt + 8'd1;
          end else if (tmo_hit) begin
            if (last_try) begin
              state <= st_failed;
            end else begin
              state     <= st_request;
              retry_cnt <= retry_cnt + 4'd1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Offered lease and server, echoed in the REQUEST options
  always_ff @(posedge clk) begin
    if ((state == st_offer_wait) && msg_match && (msg_type == msg_offer)) begin
      req_ip <= msg_yiaddr;
      srv_ip <= msg_server_id;
    end
  end

  // The framer takes up every send on the next edge
  a_send_accepted: assert property (@(posedge clk) disable iff (fsm_rst)
    send |=> busy);

endmodule

//--- verilog/dhcp_tx_framer.sv
`timescale 1ns/1ps
`include "dhcp_params.svh"

module dhcp_tx_framer (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                send,
  input  dhcp_pkg::dhcp_msg_t send_type,
  input  logic [31:0]         xid,
  input  dhcp_pkg::ipv4_t     req_ip,
  input  dhcp_pkg::ipv4_t     srv_ip,
  input  dhcp_pkg::mac_t      mac,
  output logic                busy,
  output logic [7:0]          tx_data,
  output logic                tx_valid,
  output logic                tx_last,
  input  logic                tx_ready
);
  import dhcp_pkg::*;

  localparam logic [5:0]  disc_last    = 6'd26;
  localparam logic [5:0]  req_last     = 6'd38;
  localparam logic [31:0] magic_cookie = `DHCP_COOKIE;

  logic [5:0]  idx;
  logic [5:0]  last_idx;
  dhcp_msg_t   type_q;
  logic [31:0] xid_q;
  ipv4_t       req_q;
  ipv4_t       srv_q;
  mac_t        mac_q;

  assign busy     = tx_valid;
  assign last_idx = (type_q == msg_request) ? req_last : disc_last;
  assign tx_last  = tx_valid && (idx == last_idx);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_valid <= 1'b0;
      idx      <= '0;
    end else if (send && !tx_valid) begin
      tx_valid <= 1'b1;
      idx      <= '0;
    end else if (tx_valid && tx_ready) begin
      if (idx == last_idx) begin
        tx_valid <= 1'b0;
      end else begin
        idx <= idx + 6'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send && !tx_valid) begin
      type_q <= send_type;
      xid_q  <= xid;
      req_q  <= req_ip;
      srv_q  <= srv_ip;
      mac_q  <= mac;
    end
  end

  // Byte at the current index, multi-byte fields go out MSB first
  always_comb begin
    case (idx) inside
      6'd0:            tx_data = op_request;
      [6'd1:6'd4]:     tx_data = xid_q[8 * (4 - idx) +: 8];
      [6'd13:6'd18]:   tx_data = mac_q[8 * (18 - idx) +: 8];
      [6'd19:6'd22]:   tx_data = magic_cookie[8 * (22 - idx) +: 8];
      6'd23:           tx_data = opt_msg_type;
      6'd24:           tx_data = 8'd1;
      6'd25:           tx_data = type_q;
      6'd26:           tx_data = (type_q == msg_request) ? opt_req_ip : opt_end;
      6'd27, 6'd33:    tx_data = 8'd4;
      [6'd28:6'd31]:   tx_data = req_q[8 * (31 - idx) +: 8];
      6'd32:           tx_data = opt_server_id;
      [6'd34:6'd37]:   tx_data = srv_q[8 * (37 - idx) +: 8];
      6'd38:           tx_data = opt_end;
      default:         tx_data = 8'h00;
    endcase
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

//--- verilog/dhcp_rx_parser.sv
`timescale 1ns/1ps
`include "dhcp_params.svh"

module dhcp_rx_parser (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic [7:0]          rx_data,
  input  logic                rx_valid,
  input  logic                rx_last,
  input  dhcp_pkg::mac_t      mac,
  output logic                msg_val,
  output dhcp_pkg::dhcp_msg_t msg_type,
  output logic [31:0]         msg_xid,
  output dhcp_pkg::ipv4_t     msg_yiaddr,
  output dhcp_pkg::ipv4_t     msg_server_id
);
  import dhcp_pkg::*;

  typedef enum logic [2:0] {ps_hdr, ps_code, ps_len, ps_val, ps_end} parse_state_t;

  localparam logic [31:0] magic_cookie = `DHCP_COOKIE;

  parse_state_t pst;
  logic [4:0]   hidx;
  logic [7:0]   code_q;
  logic [7:0]   len_q;
  logic [7:0]   vcnt;
  logic         op_ok;
  logic         ck_ok;
  logic         ch_ok;
  logic         type_seen;
  logic         end_ok;
  logic [7:0]   type_q;
  logic [31:0]  xid_q;
  ipv4_t        yia_q;
  ipv4_t        sid_q;

  // The closing byte may itself be the end option
  assign end_ok = (pst == ps_end) || ((pst == ps_code) && (rx_data == opt_end));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pst       <= ps_hdr;
      hidx      <= '0;
      code_q    <= '0;
      len_q     <= '0;
      vcnt      <= '0;
      op_ok     <= 1'b0;
      ck_ok     <= 1'b0;
      ch_ok     <= 1'b0;
      type_seen <= 1'b0;
      msg_val   <= 1'b0;
    end else begin
      msg_val <= 1'b0;
      if (rx_valid && rx_last) begin
        msg_val <= op_ok && ck_ok && ch_ok && type_seen && end_ok;
        pst     <= ps_hdr;
        hidx    <= '0;
      end else if (rx_valid) begin
        case (pst)
          ps_hdr: begin
            hidx <= hidx + 5'd1;
            if (hidx == 5'd0) begin
              op_ok     <= (rx_data == op_reply);
              ck_ok     <= 1'b1;
              ch_ok     <= 1'b1;
              type_seen <= 1'b0;
            end
            if ((hidx inside {[5'd13:5'd18]}) && (rx_data != mac[8 * (18 - hidx) +: 8])) begin
              ch_ok <= 1'b0;
            end
            if ((hidx inside {[5'd19:5'd22]}) &&
                (rx_data != magic_cookie[8 * (22 - hidx) +: 8])) begin
              ck_ok <= 1'b0;
            end
            if (hidx == 5'd22) begin
              pst <= ps_code;
            end
          end
          ps_code: begin
            if (rx_data == opt_end) begin
              pst <= ps_end;
            end else if (rx_data != opt_pad) begin
              code_q <= rx_data;
              pst    <= ps_len;
            end
          end
          ps_len: begin
            len_q <= rx_data;
            vcnt  <= '0;
            pst   <= (rx_data == 8'd0) ? ps_code : ps_val;
          end
          ps_val: begin
            vcnt <= vcnt + 8'd1;
            if (code_q == opt_msg_type) begin
              type_seen <= 1'b1;
            end
            if (vcnt == len_q - 8'd1) begin
              pst <= ps_code;
            end
          end
          default: pst <= ps_end;
        endcase
      end
    end
  end

  // Field capture, handed to the outputs with the last byte
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if ((pst == ps_hdr) && (hidx == 5'd0)) begin
        type_q <= '0;
        sid_q  <= '0;
      end
      if ((pst == ps_hdr) && (hidx inside {[5'd1:5'd4]})) begin
        xid_q <= {xid_q[23:0], rx_data};
      end
      if ((pst == ps_hdr) && (hidx inside {[5'd5:5'd8]})) begin
        yia_q <= {yia_q[23:0], rx_data};
      end
      if ((pst == ps_val) && (code_q == opt_msg_type) && (vcnt == 8'd0)) begin
        type_q <= rx_data;
      end
      if ((pst == ps_val) && (code_q == opt_server_id) && (vcnt < 8'd4)) begin
        sid_q <= {sid_q[23:0], rx_data};
      end
      if (rx_last) begin
        msg_type      <= dhcp_msg_t'(type_q);
        msg_xid       <= xid_q;
        msg_yiaddr    <= yia_q;
        msg_server_id <= sid_q;
      end
    end
  end

  a_msg_pulse: assert property (@(posedge clk) disable iff (fsm_rst)
    msg_val |=> !msg_val);

endmodule

//--- verilog/dhcp_client_top.sv
`timescale 1ns/1ps

module dhcp_client_top (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic [7:0]  tx_data,
  output logic        tx_valid,
  input  logic        tx_ready,
  output logic        tx_last,
  input  logic [7:0]  rx_data,
  input  logic        rx_valid,
  input  logic        rx_last
);
  import dhcp_pkg::*;

  logic        start;
  logic        send;
  logic        busy;
  logic        msg_val;
  logic [31:0] xid;
  logic [31:0] msg_xid;
  dhcp_msg_t   send_type;
  dhcp_msg_t   msg_type;
  dhcp_state_t state;
  mac_t        mac;
  ipv4_t       req_ip;
  ipv4_t       srv_ip;
  ipv4_t       lease_ip;
  ipv4_t       server_ip;
  ipv4_t       msg_yiaddr;
  ipv4_t       msg_server_id;

  dhcp_apb_regs u_regs (
    .clk(clk), .fsm_rst(fsm_rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .start(start), .mac(mac),
    .state(state), .lease_ip(lease_ip), .server_ip(server_ip)
  );

  dhcp_core u_core (
    .clk(clk), .fsm_rst(fsm_rst), .start(start), .busy(busy),
    .msg_val(msg_val), .msg_type(msg_type), .msg_xid(msg_xid),
    .msg_yiaddr(msg_yiaddr), .msg_server_id(msg_server_id),
    .send(send), .send_type(send_type), .xid(xid), .req_ip(req_ip), .srv_ip(srv_ip),
    .state(state), .lease_ip(lease_ip), .server_ip(server_ip)
  );

  dhcp_tx_framer u_tx (
    .clk(clk), .fsm_rst(fsm_rst),
    .send(send), .send_type(send_type), .xid(xid),
    .req_ip(req_ip), .srv_ip(srv_ip), .mac(mac), .busy(busy),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready)
  );

  dhcp_rx_parser u_rx (
    .clk(clk), .fsm_rst(fsm_rst),
    .rx_data(rx_data), .rx_valid(rx_valid), .rx_last(rx_last), .mac(mac),
    .msg_val(msg_val), .msg_type(msg_type), .msg_xid(msg_xid),
    .msg_yiaddr(msg_yiaddr), .msg_server_id(msg_server_id)
  );

endmodule

//--- bench/tb_dhcp_client.sv
`timescale 1ns/1ps
`include "dhcp_params.svh"

module tb_dhcp_client;
  import dhcp_pkg::*;

  logic        clk;
  logic        fsm_rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  tx_data;
  logic        tx_valid;
  logic        tx_ready;
  logic        tx_last;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic        rx_last;

  integer     seed = 32'h6562c821;
  int         errors = 0;
  int         tests = 0;
  int         xid_n = 0;
  int         frames_seen = 0;
  bit         was_idle = 1'b1;
  bit         stall_en = 1'b0;
  mac_t       mac_m;
  logic [7:0] frame[$];

  dhcp_client_top u_dut (
    .clk(clk), .fsm_rst(fsm_rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_last(tx_last),
    .rx_data(rx_data), .rx_valid(rx_valid), .rx_last(rx_last)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Random back-pressure on the transmit stream when enabled
  always @(posedge clk) begin
    #2;
    tx_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  always @(negedge clk) begin
    if (tx_valid && tx_ready && tx_last) begin
      frames_seen <= frames_seen + 1;
    end
  end

  initial begin
    #(6 * (3 * `DHCP_TIMEOUT_CYCLES + 400) * 40);
    $display("Watchdog expired before the tests completed");
    $display("TB FAILED");
    $finish;
  end

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_ip(input string name, input ipv4_t got, input ipv4_t exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input dhcp_state_t got, input dhcp_state_t exp);
    if (got !== exp) begin
      $display("ERR state: got %h expected %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_apb_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wd,
                          output logic [31:0] rd, output logic err);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wd;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #10;
    rd  = prdata;
    err = pslverr;
    check_apb_err("pready", pready, 1'b1);
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_state(input dhcp_state_t exp);
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    st = '0;
    while (st[5:4] == 2'b00 && polls < 3000) begin
      apb_xfer(1'b0, reg_status, 32'd0, st, err);
      polls++;
    end
    if (st[5:4] == 2'b00) begin
      $display("Client never reached a final state");
      errors++;
    end
    check_state(dhcp_state_t'(st[2:0]), exp);
    check_byte("reg_status", st[7:0], {2'b00, exp == st_failed, exp == st_bound, 1'b0, exp});
  endtask

  // Collect one transmitted frame, sampled mid-cycle
  task automatic get_frame;
    int n;
    n = 0;
    frame.delete();
    while (1) begin
      @(negedge clk);
      if (tx_valid && tx_ready) begin
        frame.push_back(tx_data);
        if (tx_last) break;
      end
      n++;
      if (n > 3000) begin
        $display("Timed out waiting for a transmitted frame");
        errors++;
        break;
      end
    end
  endtask

  task automatic push_word(inout logic [7:0] q[$], input logic [31:0] w);
    for (int i = 3; i >= 0; i--) q.push_back(w[8 * i +: 8]);
  endtask

  task automatic check_frame(input dhcp_msg_t mt, input ipv4_t req, input ipv4_t srv);
    logic [7:0] exp[$];
    exp.push_back(8'd1);
    push_word(exp, `DHCP_XID_BASE + xid_n);
    for (int i = 0; i < 8; i++) exp.push_back(8'd0);
    for (int i = 5; i >= 0; i--) exp.push_back(mac_m[8 * i +: 8]);
    push_word(exp, `DHCP_COOKIE);
    exp.push_back(8'd53);
    exp.push_back(8'd1);
    exp.push_back(mt);
    if (mt == msg_request) begin
      exp.push_back(8'd50);
      exp.push_back(8'd4);
      push_word(exp, req);
      exp.push_back(8'd54);
      exp.push_back(8'd4);
      push_word(exp, srv);
    end
    exp.push_back(8'd255);
    if (frame.size() != exp.size()) begin
      $display("Frame has %0d bytes where %0d were expected", frame.size(), exp.size());
      errors++;
    end else begin
      for (int i = 0; i < exp.size(); i++) check_byte($sformatf("tx_data[%0d]", i),
                                                      frame[i], exp[i]);
    end
  endtask

  // Server reply with a few random options that the client has to skip
  task automatic send_reply(input dhcp_msg_t mt, input logic [31:0] x, input ipv4_t yia,
                            input ipv4_t sid, input mac_t ch, input logic [31:0] cookie);
    logic [7:0] q[$];
    int         extra;
    int         len;
    q.push_back(8'd2);
    push_word(q, x);
    push_word(q, yia);
    push_word(q, sid);
    for (int i = 5; i >= 0; i--) q.push_back(ch[8 * i +: 8]);
    push_word(q, cookie);
    extra = $random(seed) & 3;
    for (int e = 0; e < extra; e++) begin
      q.push_back(8'd60 + 8'($random(seed) & 31));
      len = $random(seed) & 3;
      q.push_back(8'(len));
      for (int i = 0; i < len; i++) q.push_back(8'($random(seed)));
    end
    q.push_back(8'd53);
    q.push_back(8'd1);
    q.push_back(mt);
    q.push_back(8'd54);
    q.push_back(8'd4);
    push_word(q, sid);
    q.push_back(8'd255);
    for (int i = 0; i < q.size(); i++) begin
      @(posedge clk);
      #2;
      rx_valid = 1'b1;
      rx_data  = q[i];
      rx_last  = (i == q.size() - 1);
    end
    @(posedge clk);
    #2;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  task automatic run_lease(input bit filter, input bit nak);
    logic [31:0] rd;
    logic        err;
    logic [31:0] x;
    ipv4_t       offer_ip;
    ipv4_t       srv;
    apb_xfer(1'b1, reg_ctrl, 32'd1, rd, err);
    if (!was_idle) xid_n++;
    was_idle = 1'b0;
    for (int r = 0; r <= int'(nak); r++) begin
      get_frame();
      check_frame(msg_discover, '0, '0);
      x        = `DHCP_XID_BASE + xid_n;
      offer_ip = ipv4_t'($random(seed));
      srv      = ipv4_t'($random(seed));
      if (filter) begin
        send_reply(msg_offer, x + 32'h100, offer_ip ^ 32'h1, srv, mac_m, `DHCP_COOKIE);
        send_reply(msg_offer, x, offer_ip ^ 32'h2, srv, mac_m ^ 48'h1, `DHCP_COOKIE);
        send_reply(msg_offer, x, offer_ip ^ 32'h4, srv, mac_m, `DHCP_COOKIE ^ 32'h1);
      end
      send_reply(msg_offer, x, offer_ip, srv, mac_m, `DHCP_COOKIE);
      get_frame();
      check_frame(msg_request, offer_ip, srv);
      if (r < int'(nak)) begin
        send_reply(msg_nak, x, 32'd0, srv, mac_m, `DHCP_COOKIE);
        xid_n++;
      end
    end
    send_reply(msg_ack, x, offer_ip, srv, mac_m, `DHCP_COOKIE);
    wait_state(st_bound);
    apb_xfer(1'b0, reg_lease_ip, 32'd0, rd, err);
    check_ip("reg_lease_ip", rd, offer_ip);
    apb_xfer(1'b0, reg_server_ip, 32'd0, rd, err);
    check_ip("reg_server_ip", rd, srv);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          e0;
    int          c0;
    fsm_rst  = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    tx_ready = 1'b1;
    rx_data  = '0;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    fsm_rst = 1'b0;

    e0 = errors;
    mac_m = {16'($random(seed)), 32'($random(seed))};
    apb_xfer(1'b1, reg_mac_lo, mac_m[31:0], rd, err);
    check_apb_err("pslverr", err, 1'b0);
    apb_xfer(1'b1, reg_mac_hi, {16'd0, mac_m[47:32]}, rd, err);
    apb_xfer(1'b0, reg_mac_lo, 32'd0, rd, err);
    check_ip("reg_mac_lo", rd, mac_m[31:0]);
    apb_xfer(1'b0, reg_mac_hi, 32'd0, rd, err);
    check_ip("reg_mac_hi", rd, {16'd0, mac_m[47:32]});
    apb_xfer(1'b0, 8'h20, 32'd0, rd, err);
    check_apb_err("pslverr", err, 1'b1);
    check_ip("prdata", rd, 32'd0);
    apb_xfer(1'b0, reg_status, 32'd0, rd, err);
    check_state(dhcp_state_t'(rd[2:0]), st_idle);
    end_test("registers", e0);

    e0 = errors;
    run_lease(1'b0, 1'b0);
    end_test("normal lease", e0);

    e0 = errors;
    run_lease(1'b1, 1'b0);
    end_test("filtering", e0);

    e0 = errors;
    run_lease(1'b0, 1'b1);
    end_test("nak restart", e0);

    e0 = errors;
    stall_en = 1'b1;
    run_lease(1'b0, 1'b0);
    run_lease(1'b0, 1'b0);
    stall_en = 1'b0;
    end_test("back-pressure", e0);

    e0 = errors;
    c0 = frames_seen;
    apb_xfer(1'b1, reg_ctrl, 32'd1, rd, err);
    xid_n++;
    for (int i = 0; i < `DHCP_MAX_RETRIES; i++) begin
      get_frame();
      check_frame(msg_discover, '0, '0);
      if (i < `DHCP_MAX_RETRIES - 1) xid_n++;
    end
    wait_state(st_failed);
    if (frames_seen - c0 != `DHCP_MAX_RETRIES) begin
      $display("Client sent %0d frames without replies", frames_seen - c0);
      errors++;
    end
    end_test("silence", e0);

    $display("Tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- dhcp_client_top.f
+incdir+verilog
verilog/dhcp_pkg.sv
verilog/dhcp_apb_regs.sv
verilog/dhcp_core.sv
verilog/dhcp_tx_framer.sv
verilog/dhcp_rx_parser.sv
verilog/dhcp_client_top.sv
bench/tb_dhcp_client.sv

//--- run_sim.sh
#!/bin/sh
# Build the DHCP client testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dhcp_client \
  -f dhcp_client_top.f -Mdir obj_dir -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "TB PASSED" "$SIM_LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi
exit 0
